// File: include/sub_config.svh
`ifndef SUB_CONFIG_SVH
`define SUB_CONFIG_SVH

// sub cpu clock enable ratio
// cpu_cen fires SUB_CEN_NUM times every SUB_CEN_DEN clk
`define SUB_CEN_NUM 29
`define SUB_CEN_DEN 146

// ratio accumulator width, must hold SUB_CEN_DEN - 1
`define SUB_CEN_W 8

// rom word address, 256 kwords of program
`define SUB_ROM_AW 18

`endif

// File: hdl/sub_bus_pkg.sv
`include "sub_config.svh"

package sub_bus_pkg;

    typedef logic [19:1] addr_t;     // word address, a0 is implied by the strobes
    typedef logic [15:0] data_t;
    typedef logic [1:0]  dsn_t;      // {udsn, ldsn}, active low
    typedef logic [2:0]  fc_t;
    typedef logic [`SUB_ROM_AW-1:0] rom_addr_t;

    // one bus master's view of a cycle
    typedef struct packed {
        addr_t addr;
        dsn_t  dsn;
        logic  rnw;
    } bus_req_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic road;  // road ram
        logic sio;   // road i/o
    } chip_sel_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,
        ARB_GRANT,
        ARB_OWN
    } arb_state_e;

endpackage

// File: hdl/sub_bus_timing.sv
`timescale 1ns/1ps
`include "sub_config.svh"

module sub_bus_timing (
    input  logic              clk,
    input  logic              rst,
    input  logic              bus_cs,
    input  logic              bus_busy,
    input  logic              cpu_asn,
    input  sub_bus_pkg::dsn_t dsn,
    input  sub_bus_pkg::fc_t  cpu_fc,
    input  logic              irqn,
    output logic              cpu_cen,
    output logic              cpu_cenb,
    output logic              dtackn,
    output logic              vpan,
    output sub_bus_pkg::fc_t  ipln
);
    import sub_bus_pkg::*;

    localparam logic [`SUB_CEN_W:0] CEN_NUM  = `SUB_CEN_NUM;
    localparam logic [`SUB_CEN_W:0] CEN_DEN  = `SUB_CEN_DEN;
    localparam logic [`SUB_CEN_W:0] CEN_HALF = `SUB_CEN_DEN / 2;

    logic [`SUB_CEN_W-1:0] acc;
    logic [`SUB_CEN_W:0]   acc_sum;  // extra bit so the sum can pass den
    logic [`SUB_CEN_W:0]   acc_wrap;
    logic                  inta;
    logic                  strb_q;
    logic                  mem_rdy;

    assign acc_sum  = {1'b0, acc} + CEN_NUM;
    assign acc_wrap = acc_sum - CEN_DEN;

    // fractional divider, frozen while memory holds the bus
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc      <= '0;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else if (bus_busy) begin
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else begin
            // half point crossed once per period
            cpu_cenb <= ({1'b0, acc} < CEN_HALF) && (acc_sum >= CEN_HALF);
            if (acc_sum >= CEN_DEN) begin
                acc     <= acc_wrap[`SUB_CEN_W-1:0];
                cpu_cen <= 1'b1;
            end else begin
                acc     <= acc_sum[`SUB_CEN_W-1:0];
                cpu_cen <= 1'b0;
            end
        end
    end

    // fc = x11 is an interrupt acknowledge cycle
    assign inta = &cpu_fc[1:0];
    assign vpan = ~(~cpu_asn & inta);  // autovector request
    assign ipln = {irqn, 2'b11};       // single level interrupt

    // the selects lag the strobe by one clk, so busy is only
    // meaningful once the strobe has been seen for a cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            strb_q <= 1'b0;
        end else begin
            strb_q <= ~cpu_asn & ~&dsn;
        end
    end

    assign mem_rdy = strb_q & (~bus_cs | ~bus_busy);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtackn <= 1'b1;
        end else if (cpu_asn || inta) begin
            dtackn <= 1'b1;  // cycle over or vpa path
        end else if (cpu_cen && mem_rdy) begin
            dtackn <= 1'b0;
        end
    end

endmodule

// File: hdl/sub_bus_arbiter.sv
`timescale 1ns/1ps

module sub_bus_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic cpu_cen,
    input  logic main_br,
    input  logic bgn,
    input  logic cpu_asn,
    output logic brn,
    output logic bgackn
);
    import sub_bus_pkg::*;

    arb_state_e state;

    // steps at the sub cpu rate so the 68000 sees a clean sequence
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else if (cpu_cen) begin
            case (state)
                ARB_IDLE: begin
                    if (main_br) state <= ARB_REQ;
                end
                ARB_REQ: begin
                    if (!main_br) begin
                        state <= ARB_IDLE;  // request withdrawn
                    end else if (!bgn) begin
                        state <= ARB_GRANT;
                    end
                end
                ARB_GRANT: begin
                    // wait for the running cycle to finish
                    if (cpu_asn) state <= ARB_OWN;
                end
                ARB_OWN: begin
                    if (!main_br) state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign brn    = ~((state == ARB_REQ) || (state == ARB_GRANT));
    assign bgackn = ~(state == ARB_OWN);

endmodule

// File: hdl/sub_mem_map.sv
`timescale 1ns/1ps
`include "sub_config.svh"

module sub_mem_map (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   bgackn,
    input  sub_bus_pkg::bus_req_t  cpu_req,
    input  sub_bus_pkg::bus_req_t  main_req,
    input  logic                   cpu_asn,
    input  sub_bus_pkg::data_t     cpu_dout,
    input  sub_bus_pkg::data_t     main_dout,
    input  logic                   rom_ok,
    input  logic                   ram_ok,
    input  sub_bus_pkg::data_t     rom_data,
    input  sub_bus_pkg::data_t     ram_data,
    output sub_bus_pkg::chip_sel_t cs,
    output sub_bus_pkg::rom_addr_t rom_addr,
    output sub_bus_pkg::data_t     bus_dout,
    output sub_bus_pkg::data_t     cpu_din,
    output sub_bus_pkg::dsn_t      dswn,
    output logic                   bus_cs,
    output logic                   bus_busy,
    output logic                   main_ok,
    output sub_bus_pkg::dsn_t      bus_dsn
);
    import sub_bus_pkg::*;

    bus_req_t  bus_req;
    chip_sel_t cs_dec;
    logic      bus_strb;
    logic      access;

    // main cpu owns the bus while bgackn is low
    assign bus_req  = bgackn ? cpu_req : main_req;
    assign bus_dout = bgackn ? cpu_dout : main_dout;
    assign bus_dsn  = bus_req.dsn;

    assign bus_strb = ~&bus_req.dsn;
    assign dswn     = bus_req.dsn | {2{bus_req.rnw}};  // reads never write
    assign access   = bus_strb | ~bgackn | (~cpu_asn & bus_req.rnw);

    // map on a19..a17
    always_comb begin
        cs_dec = '0;
        case (bus_req.addr[19:17])
            3'd0, 3'd1, 3'd2: cs_dec.rom = 1'b1;
            3'd3: cs_dec.ram = bus_strb;
            3'd4: begin
                cs_dec.road = ~bus_req.addr[16];
                cs_dec.sio  = bus_req.addr[16];
            end
            default: cs_dec = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= '0;
        end else if (access) begin
            cs <= cs_dec;
        end else begin
            cs <= '0;
        end
    end

    always_ff @(posedge clk) begin
        rom_addr <= bus_req.addr[`SUB_ROM_AW:1];
    end

    // both masters read through the same return path
    always_comb begin
        if (cs.ram) begin
            cpu_din = ram_data;
        end else if (cs.rom) begin
            cpu_din = rom_data;
        end else begin
            cpu_din = '1;  // open bus
        end
    end

    assign bus_cs   = cs.rom | cs.ram;
    assign bus_busy = (cs.rom & ~rom_ok) | (cs.ram & ~ram_ok);
    assign main_ok  = ~bgackn & ~bus_busy;

endmodule

// File: hdl/outrun_sub_bus.sv
`timescale 1ns/1ps

module outrun_sub_bus (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   irqn,     // shared with the main cpu

    // main cpu side
    input  logic                   main_br,
    input  sub_bus_pkg::bus_req_t  main_req,
    input  sub_bus_pkg::data_t     main_dout,
    output sub_bus_pkg::data_t     main_din,
    output logic                   main_ok,

    // sub cpu pins
    input  sub_bus_pkg::bus_req_t  cpu_req,
    input  logic                   cpu_asn,
    input  sub_bus_pkg::fc_t       cpu_fc,
    input  sub_bus_pkg::data_t     cpu_dout,
    output sub_bus_pkg::data_t     cpu_din,
    input  logic                   bgn,
    output logic                   brn,
    output logic                   bgackn,
    output logic                   dtackn,
    output logic                   vpan,
    output sub_bus_pkg::fc_t       ipln,
    output logic                   cpu_cen,
    output logic                   cpu_cenb,

    // memory side
    output sub_bus_pkg::data_t     bus_dout,
    output sub_bus_pkg::dsn_t      dswn,
    output sub_bus_pkg::rom_addr_t rom_addr,
    output logic                   rom_cs,
    input  logic                   rom_ok,
    input  sub_bus_pkg::data_t     rom_data,
    output logic                   ram_cs,
    input  logic                   ram_ok,
    input  sub_bus_pkg::data_t     ram_data,
    output logic                   road_cs,
    output logic                   sio_cs
);
    import sub_bus_pkg::*;

    chip_sel_t cs;
    dsn_t      bus_dsn;
    logic      bus_cs;
    logic      bus_busy;

    assign rom_cs   = cs.rom;
    assign ram_cs   = cs.ram;
    assign road_cs  = cs.road;
    assign sio_cs   = cs.sio;
    assign main_din = cpu_din;

    sub_bus_timing u_timing (
        .clk      (clk),
        .rst      (rst),
        .bus_cs   (bus_cs),
        .bus_busy (bus_busy),
        .cpu_asn  (cpu_asn),
        .dsn      (bus_dsn),
        .cpu_fc   (cpu_fc),
        .irqn     (irqn),
        .cpu_cen  (cpu_cen),
        .cpu_cenb (cpu_cenb),
        .dtackn   (dtackn),
        .vpan     (vpan),
        .ipln     (ipln)
    );

    sub_bus_arbiter u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .cpu_cen (cpu_cen),
        .main_br (main_br),
        .bgn     (bgn),
        .cpu_asn (cpu_asn),
        .brn     (brn),
        .bgackn  (bgackn)
    );

    sub_mem_map u_mem_map (
        .clk       (clk),
        .rst       (rst),
        .bgackn    (bgackn),
        .cpu_req   (cpu_req),
        .main_req  (main_req),
        .cpu_asn   (cpu_asn),
        .cpu_dout  (cpu_dout),
        .main_dout (main_dout),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .cs        (cs),
        .rom_addr  (rom_addr),
        .bus_dout  (bus_dout),
        .cpu_din   (cpu_din),
        .dswn      (dswn),
        .bus_cs    (bus_cs),
        .bus_busy  (bus_busy),
        .main_ok   (main_ok),
        .bus_dsn   (bus_dsn)
    );

endmodule

// File: dv/tb_outrun_sub_bus.sv
`timescale 1ns/1ps
`include "sub_config.svh"

module tb_outrun_sub_bus;
    import sub_bus_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 10;
    localparam int CEN_CYCLES  = 292;  // two full ratio periods
    localparam int WAIT_LIMIT  = 40;   // longest wait for one bus event
    localparam int NUM_WAITS   = 30;   // bus events over all tests
    localparam int WATCHDOG_NS = 2 * CLK_PERIOD *
                                 (RST_CYCLES + CEN_CYCLES + NUM_WAITS * WAIT_LIMIT);

    // index into watch
    localparam int W_DTACKN = 0;
    localparam int W_BRN    = 1;
    localparam int W_BGACKN = 2;
    localparam int W_ROM_OK = 3;
    localparam int W_RAM_OK = 4;

    logic      clk, rst, irqn;
    logic      main_br, main_ok, bgn, brn, bgackn;
    logic      cpu_asn, cpu_cen, cpu_cenb, dtackn, vpan;
    logic      rom_cs, ram_cs, road_cs, sio_cs, rom_ok, ram_ok;
    bus_req_t  main_req, cpu_req;
    data_t     main_dout, main_din, cpu_dout, cpu_din, bus_dout, rom_data, ram_data;
    fc_t       cpu_fc, ipln;
    dsn_t      dswn;
    rom_addr_t rom_addr;
    integer    seed;
    int        rom_wait, ram_wait, busy_cycles;
    logic      busy_q, mem_busy;
    logic [4:0] watch;

    outrun_sub_bus DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // memory contents depend on every address bit
    function automatic data_t rom_word(input rom_addr_t a);
        rom_word = a[15:0] ^ {a[17:16], 14'h2b1d};
    endfunction

    function automatic data_t ram_word(input rom_addr_t a);
        ram_word = {a[7:0], a[15:8]} ^ {14'h1c3a, a[17:16]};
    endfunction

    assign rom_data = rom_word(rom_addr);
    assign ram_data = ram_word(rom_addr);
    assign mem_busy = (rom_cs && !rom_ok) || (ram_cs && !ram_ok);
    assign watch    = {ram_ok, rom_ok, bgackn, brn, dtackn};

    // responders answer 1 to 3 clk after their select
    always @(posedge clk) begin
        #2;
        if (!rom_cs) begin
            rom_ok   = 1'b0;
            rom_wait = 1 + {$random(seed)} % 3;
        end else if (rom_wait > 0) begin
            rom_wait = rom_wait - 1;
        end else begin
            rom_ok = 1'b1;
        end
        if (!ram_cs) begin
            ram_ok   = 1'b0;
            ram_wait = 1 + {$random(seed)} % 3;
        end else if (ram_wait > 0) begin
            ram_wait = ram_wait - 1;
        end else begin
            ram_ok = 1'b1;
        end
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // back-pressure and main_ok rules hold on every cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (busy_q) begin
                check_eq(cpu_cen, 1'b0, "cpu_cen while memory busy");
                busy_cycles = busy_cycles + 1;
            end
            if (mem_busy)
                check_eq(dtackn, 1'b1, "dtackn low before memory ok");
            check_eq(main_ok, !bgackn && !mem_busy, "main_ok against memory ok");
            busy_q = mem_busy;
        end
    end

    task automatic await(input int sig, input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (watch[sig] !== level) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("Error at %0t: timed out waiting for %s", $time, what);
                $display("Simulation FAILED");
                $fatal(1);
            end
        end
    endtask

    task automatic end_cycle();
        @(posedge clk);
        #2;
        cpu_asn     = 1'b1;
        cpu_req.dsn = 2'b11;
        cpu_req.rnw = 1'b1;
        await(W_DTACKN, 1'b1, "dtackn release");
    endtask

    task automatic cpu_read(input logic [19:0] ba, input dsn_t strobes,
                            output data_t d, output logic [3:0] sel);
        @(posedge clk);
        #2;
        cpu_req.addr = ba[19:1];
        cpu_req.dsn  = strobes;
        cpu_req.rnw  = 1'b1;
        cpu_fc       = 3'b101;  // supervisor data
        cpu_asn      = 1'b0;
        await(W_DTACKN, 1'b0, "dtackn on a cpu read");
        d   = cpu_din;
        sel = {rom_cs, ram_cs, road_cs, sio_cs};
        check_eq(rom_addr, ba[`SUB_ROM_AW:1], "rom_addr of a cpu read");
        check_eq(dswn, 2'b11, "dswn during a read");
        end_cycle();
    endtask

    task automatic cpu_write(input logic [19:0] ba, input dsn_t strobes, input data_t wd);
        @(posedge clk);
        #2;
        cpu_req.addr = ba[19:1];
        cpu_req.dsn  = strobes;
        cpu_req.rnw  = 1'b0;
        cpu_dout     = wd;
        cpu_asn      = 1'b0;
        await(W_DTACKN, 1'b0, "dtackn on a cpu write");
        check_eq(dswn, strobes, "dswn during a write");
        check_eq(bus_dout, wd, "cpu write data on the bus");
        end_cycle();
    endtask

    task automatic map_read(input logic [19:0] ba, input logic [3:0] exp_sel);
        data_t      d;
        logic [3:0] sel;
        cpu_read(ba, 2'b00, d, sel);
        check_eq(sel, exp_sel, "chip select for the address");
        if (exp_sel[3])
            check_eq(d, rom_word(ba[`SUB_ROM_AW:1]), "rom read data");
        if (exp_sel[2])
            check_eq(d, ram_word(ba[`SUB_ROM_AW:1]), "ram read data");
    endtask

    task automatic main_access(input logic [19:0] ba, input logic rnw, input dsn_t strobes,
                               input logic [3:0] exp_sel);
        @(posedge clk);
        #2;
        main_req.addr = ba[19:1];
        main_req.dsn  = strobes;
        main_req.rnw  = rnw;
        main_dout     = ba[15:0] ^ 16'h0f0f;
        @(posedge clk);  // selects register one clk later
        @(negedge clk);
        check_eq({rom_cs, ram_cs, road_cs, sio_cs}, exp_sel, "selects from main_req");
        await(exp_sel[3] ? W_ROM_OK : W_RAM_OK, 1'b1, "memory ok for the main cpu");
        if (rnw) begin
            check_eq(main_din, rom_word(ba[`SUB_ROM_AW:1]), "main cpu read data");
        end else begin
            check_eq(dswn, strobes, "dswn for a main cpu write");
            check_eq(bus_dout, main_dout, "main write data on the bus");
        end
        @(posedge clk);
        #2;
        main_req = '1;  // park on an unmapped address
    endtask

    task automatic count_cen_pulses();
        int cens;
        int cenbs;
        cens  = 0;
        cenbs = 0;
        for (int i = 1; i <= CEN_CYCLES; i++) begin
            @(posedge clk);
            @(negedge clk);
            if (cpu_cenb)
                cenbs++;
            if (cpu_cen) begin
                check_eq(cenbs, 1, "cpu_cenb pulses between cpu_cen");
                cens++;
                cenbs = 0;
            end
            check_eq(cens, (i * `SUB_CEN_NUM) / `SUB_CEN_DEN, "cpu_cen count");
        end
    endtask

    task automatic interrupt_ack();
        int n;
        @(posedge clk);
        #2;
        irqn         = 1'b0;
        cpu_req.addr = '1;
        cpu_req.dsn  = 2'b10;
        cpu_fc       = 3'b111;
        cpu_asn      = 1'b0;
        @(negedge clk);
        check_eq(ipln, 3'b011, "ipln with irqn low");
        check_eq(vpan, 1'b0, "vpan in interrupt acknowledge");
        n = 0;
        while (n < 3) begin  // dtackn must ignore several cpu_cen
            @(negedge clk);
            check_eq(dtackn, 1'b1, "dtackn during interrupt acknowledge");
            if (cpu_cen)
                n++;
        end
        end_cycle();
        check_eq(vpan, 1'b1, "vpan after the acknowledge");
        @(posedge clk);
        #2;
        irqn = 1'b1;
        @(negedge clk);
        check_eq(ipln, 3'b111, "ipln with irqn high");
    endtask

    task automatic bus_takeover();
        @(posedge clk);
        #2;
        main_br = 1'b1;
        await(W_BRN, 1'b0, "brn after main_br");
        check_eq(bgackn, 1'b1, "bgackn before the grant");
        @(posedge clk);
        #2;
        bgn = 1'b0;
        await(W_BGACKN, 1'b0, "bgackn after bgn");
        check_eq(brn, 1'b1, "brn while the main cpu owns the bus");
        main_access(20'h0_2468, 1'b1, 2'b00, 4'b1000);
        main_access(20'h6_0ace, 1'b0, 2'b01, 4'b0100);
        @(posedge clk);
        #2;
        main_br = 1'b0;
        await(W_BGACKN, 1'b1, "bgackn release");
        @(posedge clk);
        #2;
        bgn = 1'b1;
    endtask

    initial begin
        seed        = 58;
        clk         = 1'b0;
        rst         = 1'b1;
        irqn        = 1'b1;
        main_br     = 1'b0;
        bgn         = 1'b1;
        cpu_asn     = 1'b1;
        cpu_fc      = 3'b101;
        cpu_req     = '1;
        main_req    = '1;
        cpu_dout    = '0;
        main_dout   = '0;
        rom_ok      = 1'b0;
        ram_ok      = 1'b0;
        busy_q      = 1'b0;
        busy_cycles = 0;
        repeat (RST_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_eq({rom_cs, ram_cs, road_cs, sio_cs, cpu_cen, cpu_cenb, main_ok,
                  dtackn, vpan, brn, bgackn}, 11'b0000_000_1111, "outputs in reset");
        @(posedge clk);
        #2;
        rst = 1'b0;
        count_cen_pulses();
        map_read(20'h0_1234, 4'b1000);  // three rom banks
        map_read(20'h2_5678, 4'b1000);
        map_read(20'h4_9abc, 4'b1000);
        map_read(20'h6_0100, 4'b0100);
        map_read(20'h8_0200, 4'b0010);
        map_read(20'h9_0010, 4'b0001);
        check_eq(busy_cycles >= 4, 1'b1, "rom and ram reads held the bus busy");
        cpu_write(20'h6_1000, 2'b00, 16'hbeef);
        cpu_write(20'h6_1002, 2'b01, 16'h12ab);
        cpu_write(20'h8_0040, 2'b10, 16'h5a00);
        interrupt_ack();
        bus_takeover();
        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error at %0t: watchdog expired before the tests completed", $time);
        $display("Simulation FAILED");
        $fatal(1);
    end

endmodule

// File: files.f
+incdir+include
hdl/sub_bus_pkg.sv
hdl/sub_bus_timing.sv
hdl/sub_bus_arbiter.sv
hdl/sub_mem_map.sv
hdl/outrun_sub_bus.sv
dv/tb_outrun_sub_bus.sv
